/* vlog.f */
verilog/lsu_isa_pkg.sv
verilog/lsu_pipe_pkg.sv
verilog/lsu_opcode_decoder.sv
verilog/lsu_operand_fetch.sv
verilog/lsu_addr_calc.sv
verilog/lsu_top.sv
sim/lsu_tb_sva.sv
sim/lsu_tb.sv

/* Makefile */
# Verilator build and run of the LSU testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 --top-module lsu_tb -f vlog.f -o lsu_sim
	./obj_dir/lsu_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* sim/lsu_tb.sv */
module lsu_tb;

    localparam int NUM_SGPRS = 512;
    localparam int NUM_VGPRS = 1024;
    localparam int NUM_ROWS  = 20;

    // one table row, stimulus then expected response
    typedef struct packed {
        logic [31:0] opcode;
        logic [11:0] src1;
        logic [11:0] src2;
        logic [11:0] src3;
        logic [11:0] mem_sgpr;
        logic        rd;
        logic        wr;
        logic        gpr;
        logic [5:0]  cnt;
        logic [1:0]  depth;
        logic [3:0]  wr_mask;
        logic        illegal;
    } test_row_t;

    logic                        clk;
    logic                        reset;
    logic                        lsu_selected;
    logic [31:0]                 lsu_opcode;
    lsu_isa_pkg::operand_field_u issue_source_reg1;
    lsu_isa_pkg::operand_field_u issue_source_reg2;
    lsu_isa_pkg::operand_field_u issue_source_reg3;
    lsu_isa_pkg::operand_field_u issue_mem_sgpr;
    lsu_pipe_pkg::gpr_preload_t  preload;
    lsu_pipe_pkg::mem_req_t      mem_req;
    logic                        illegal_op;

    test_row_t   rows [NUM_ROWS];
    logic [31:0] sgpr_shadow [NUM_SGPRS];   // copy of preloaded values
    logic [31:0] vgpr_shadow [NUM_VGPRS];
    bit          sgpr_used [NUM_SGPRS];
    bit          vgpr_used [NUM_VGPRS];
    int          sgpr_list [$];
    int          vgpr_list [$];
    int          error_count;
    int          tests_run;
    int          tests_passed;
    int          cycle_count = 0;
    int          cycle_limit;

    lsu_top #(
        .NUM_SGPRS (NUM_SGPRS),
        .NUM_VGPRS (NUM_VGPRS)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .lsu_selected      (lsu_selected),
        .lsu_opcode        (lsu_opcode),
        .issue_source_reg1 (issue_source_reg1),
        .issue_source_reg2 (issue_source_reg2),
        .issue_source_reg3 (issue_source_reg3),
        .issue_mem_sgpr    (issue_mem_sgpr),
        .preload           (preload),
        .mem_req           (mem_req),
        .illegal_op        (illegal_op)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: no end of test after %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // table helpers
    ////////////////////////////////////////
    function automatic test_row_t make_row(input logic [31:0] opcode,
                                           input int s1, input int s2,
                                           input int s3, input int ms,
                                           input int rd, input int wr, input int gpr,
                                           input int cnt, input int depth,
                                           input int mask, input int illegal);
        make_row.opcode   = opcode;
        make_row.src1     = 12'(s1);
        make_row.src2     = 12'(s2);
        make_row.src3     = 12'(s3);
        make_row.mem_sgpr = 12'(ms);
        make_row.rd       = 1'(rd);
        make_row.wr       = 1'(wr);
        make_row.gpr      = 1'(gpr);
        make_row.cnt      = 6'(cnt);
        make_row.depth    = 2'(depth);
        make_row.wr_mask  = 4'(mask);
        make_row.illegal  = 1'(illegal);
    endfunction

    task automatic fill_table;
        // opcode        src1 src2 src3 msgpr rd wr gpr cnt depth mask illegal
        rows[0]  = make_row(32'h0100_0000,   3,   8,   0,  0, 1, 0, 0,  0, 0, 'b0001, 0);
        rows[1]  = make_row(32'h0100_0001,   5,  12,   0,  0, 1, 0, 0,  1, 0, 'b0011, 0);
        rows[2]  = make_row(32'h0100_0002,   7,  16,   0,  0, 1, 0, 0,  3, 0, 'b1111, 0);
        rows[3]  = make_row(32'h0100_0003,   9,  20,   0,  0, 1, 0, 0,  3, 1, 'b1111, 0);
        rows[4]  = make_row(32'h0100_0004,  11,  24,   0,  0, 1, 0, 0,  3, 2, 'b1111, 0);
        // smrd immediate offsets
        rows[5]  = make_row(32'h0100_0100, 'h2c,  8,   0,  0, 1, 0, 0,  0, 0, 'b0001, 0);
        rows[6]  = make_row(32'h0100_0103, 'h1a5, 30,  0,  0, 1, 0, 0,  3, 1, 'b1111, 0);
        rows[7]  = make_row(32'h0200_0036,  40,  41,   0,  0, 1, 0, 1,  0, 0, 'b0000, 0);
        rows[8]  = make_row(32'h0200_000d, 300, 301,   0,  0, 0, 1, 1,  0, 0, 'b0000, 0);
        // mtbuf loads then stores, depth x .. xyzw
        rows[9]  = make_row(32'h0400_0000,  50, 100, 400, 60, 1, 0, 1, 63, 0, 'b0000, 0);
        rows[10] = make_row(32'h0400_0001,  51, 101, 401, 61, 1, 0, 1, 63, 1, 'b0000, 0);
        rows[11] = make_row(32'h0400_0002,  52, 102, 402, 62, 1, 0, 1, 63, 2, 'b0000, 0);
        rows[12] = make_row(32'h0400_0003,  53, 103, 403, 63, 1, 0, 1, 63, 3, 'b0000, 0);
        rows[13] = make_row(32'h0400_0004,  54, 104, 404, 64, 0, 1, 1, 63, 0, 'b0000, 0);
        rows[14] = make_row(32'h0400_0005,  55, 105, 405, 65, 0, 1, 1, 63, 1, 'b0000, 0);
        rows[15] = make_row(32'h0400_0006,  56, 106, 406, 66, 0, 1, 1, 63, 2, 'b0000, 0);
        rows[16] = make_row(32'h0400_0007,  57, 107, 407, 67, 0, 1, 1, 63, 3, 'b0000, 0);
        // unknown opcodes and format
        rows[17] = make_row(32'h0100_0005,   2,   4,   0,  0, 0, 0, 0,  0, 0, 'b0000, 1);
        rows[18] = make_row(32'h0200_0037,  42,  43,   0,  0, 0, 0, 0,  0, 0, 'b0000, 1);
        rows[19] = make_row(32'h0800_0000,   1,   6,   0,  0, 0, 0, 0,  0, 0, 'b0000, 1);
    endtask

    task automatic mark_index(input logic [11:0] f);
        if (!sgpr_used[f[8:0]])
        begin
            sgpr_used[f[8:0]] = 1'b1;
            sgpr_list.push_back(int'(f[8:0]));
        end
        if (!vgpr_used[f[9:0]])
        begin
            vgpr_used[f[9:0]] = 1'b1;
            vgpr_list.push_back(int'(f[9:0]));
        end
    endtask

    // random pad bits, ignored by both index views
    function automatic logic [11:0] with_filler(input logic [11:0] f);
        logic [31:0] rnd;
        rnd = $urandom();
        with_filler = {rnd[1:0], f[9:0]};
    endfunction

    ////////////////////////////////////////
    // expected address and store data
    ////////////////////////////////////////
    function automatic logic [31:0] expected_addr(input test_row_t r);
        logic [7:0]  fmt;
        logic [31:0] offset;
        fmt           = r.opcode[31:24];
        expected_addr = 32'd0;
        if (fmt == lsu_isa_pkg::smrd_format)
        begin
            if (r.opcode[lsu_isa_pkg::smrd_imm_bit])
                offset = 32'(r.src1[7:0]) * 32'd4;   // dwords to bytes
            else
                offset = sgpr_shadow[r.src1[8:0]];
            expected_addr = sgpr_shadow[r.src2[8:0]] + offset;
        end
        else if (fmt == lsu_isa_pkg::ds_format)
            expected_addr = vgpr_shadow[r.src1[9:0]];
        else if (fmt == lsu_isa_pkg::mtbuf_format)
            expected_addr = sgpr_shadow[r.mem_sgpr[8:0]] + sgpr_shadow[r.src1[8:0]]
                            + vgpr_shadow[r.src3[9:0]];
    endfunction

    function automatic logic [31:0] expected_data(input test_row_t r);
        logic [7:0] fmt;
        fmt = r.opcode[31:24];
        if (fmt == lsu_isa_pkg::ds_format || fmt == lsu_isa_pkg::mtbuf_format)
            expected_data = vgpr_shadow[r.src2[9:0]];
        else
            expected_data = 32'd0;
    endfunction

    task automatic check_value(input int row, input string what,
                               input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("** Error @ %0t: row %0d %s = %h, expected %h",
                     $time, row, what, got, expected);
            error_count++;
        end
    endtask

    task automatic issue_row(input test_row_t r);
        lsu_selected      = 1'b1;
        lsu_opcode        = r.opcode;
        issue_source_reg1 = with_filler(r.src1);
        issue_source_reg2 = with_filler(r.src2);
        issue_source_reg3 = with_filler(r.src3);
        issue_mem_sgpr    = with_filler(r.mem_sgpr);
    endtask

    task automatic check_row(input int idx, input string phase);
        test_row_t r;
        int        errors_before;
        r             = rows[idx];
        errors_before = error_count;
        check_value(idx, "illegal_op", 32'(illegal_op), 32'(r.illegal));
        check_value(idx, "valid", 32'(mem_req.valid), 32'(!r.illegal));
        if (!r.illegal)
        begin
            check_value(idx, "rd", 32'(mem_req.rd), 32'(r.rd));
            check_value(idx, "wr", 32'(mem_req.wr), 32'(r.wr));
            check_value(idx, "gpr", 32'(mem_req.gpr), 32'(r.gpr));
            check_value(idx, "cnt", 32'(mem_req.cnt), 32'(r.cnt));
            check_value(idx, "depth", 32'(mem_req.depth), 32'(r.depth));
            check_value(idx, "wr_mask", 32'(mem_req.wr_mask), 32'(r.wr_mask));
            check_value(idx, "addr", mem_req.addr, expected_addr(r));
            check_value(idx, "data", mem_req.data, expected_data(r));
        end
        tests_run++;
        if (error_count == errors_before)
        begin
            tests_passed++;
            $display("%s row %0d, opcode %h: ok", phase, idx, r.opcode);
        end
        else
            $display("%s row %0d, opcode %h: FAIL", phase, idx, r.opcode);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        reset             = 1'b1;
        lsu_selected      = 1'b0;
        lsu_opcode        = 32'd0;
        issue_source_reg1 = '0;
        issue_source_reg2 = '0;
        issue_source_reg3 = '0;
        issue_mem_sgpr    = '0;
        preload           = '0;
        error_count       = 0;
        tests_run         = 0;
        tests_passed      = 0;
        cycle_limit       = 0;
        void'($urandom(32'h669acf96));

        fill_table();
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            mark_index(rows[i].src1);
            mark_index(rows[i].src2);
            mark_index(rows[i].src3);
            mark_index(rows[i].mem_sgpr);
        end
        cycle_limit = NUM_ROWS * 4 + sgpr_list.size() + vgpr_list.size() + 20;

        repeat (2) @(negedge clk);
        reset = 1'b0;

        // fill every register the table touches
        foreach (sgpr_list[k])
        begin
            sgpr_shadow[sgpr_list[k]] = $urandom();
            preload.en      = 1'b1;
            preload.is_vgpr = 1'b0;
            preload.index   = 10'(sgpr_list[k]);
            preload.data    = sgpr_shadow[sgpr_list[k]];
            @(negedge clk);
        end
        foreach (vgpr_list[k])
        begin
            vgpr_shadow[vgpr_list[k]] = $urandom();
            preload.en      = 1'b1;
            preload.is_vgpr = 1'b1;
            preload.index   = 10'(vgpr_list[k]);
            preload.data    = vgpr_shadow[vgpr_list[k]];
            @(negedge clk);
        end
        preload = '0;

        // one instruction at a time
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            issue_row(rows[i]);
            @(negedge clk);
            lsu_selected = 1'b0;
            @(negedge clk);
            check_row(i, "single");
        end

        // back to back, result of row n-2 due now
        for (int n = 0; n < NUM_ROWS + 2; n++)
        begin
            if (n >= 2)
                check_row(n - 2, "back-to-back");
            if (n < NUM_ROWS)
                issue_row(rows[n]);
            else
                lsu_selected = 1'b0;
            @(negedge clk);
        end

        $display("tests %0d, passed %0d, errors %0d", tests_run, tests_passed, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* sim/lsu_tb_sva.sv */
module lsu_tb_sva (
    input logic                      clk,
    input logic                      reset,
    input logic                      lsu_selected,
    input lsu_isa_pkg::lsu_decoded_t decoded,
    input lsu_pipe_pkg::mem_req_t    mem_req,
    input logic                      illegal_op
);

    ////////////////////////////////////////
    // request output rules
    ////////////////////////////////////////
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.rd && mem_req.wr))
        else $error("memory request with both rd and wr set");

    // illegal strobe gives illegal_op and no request
    illegal_strobe_flagged: assert property (@(posedge clk) disable iff (reset)
        (lsu_selected && !decoded.legal) |-> ##2 (illegal_op && !mem_req.valid))
        else $error("illegal strobe without illegal_op two cycles later");

    // two stages from strobe to request
    legal_strobe_request: assert property (@(posedge clk) disable iff (reset)
        (lsu_selected && decoded.legal) |-> ##2 mem_req.valid)
        else $error("legal strobe without request two cycles later");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!mem_req.valid && !illegal_op))
        else $error("output active during reset");

endmodule

bind lsu_top lsu_tb_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .lsu_selected (lsu_selected),
    .decoded      (decoded),
    .mem_req      (mem_req),
    .illegal_op   (illegal_op)
);

/* verilog/lsu_top.sv */
module lsu_top #(
    parameter int NUM_SGPRS = 512,
    parameter int NUM_VGPRS = 1024
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        lsu_selected,
    input  logic [31:0]                 lsu_opcode,
    input  lsu_isa_pkg::operand_field_u issue_source_reg1,
    input  lsu_isa_pkg::operand_field_u issue_source_reg2,
    input  lsu_isa_pkg::operand_field_u issue_source_reg3,
    input  lsu_isa_pkg::operand_field_u issue_mem_sgpr,
    input  lsu_pipe_pkg::gpr_preload_t  preload,
    output lsu_pipe_pkg::mem_req_t      mem_req,
    output logic                        illegal_op
);

    lsu_isa_pkg::lsu_decoded_t   decoded;    // comb, issue cycle
    lsu_pipe_pkg::lsu_operands_t operands;   // +1 cycle

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    lsu_opcode_decoder u_decoder (
        .lsu_selected      (lsu_selected),
        .lsu_opcode        (lsu_opcode),
        .issue_source_reg1 (issue_source_reg1),
        .issue_source_reg2 (issue_source_reg2),
        .issue_source_reg3 (issue_source_reg3),
        .issue_mem_sgpr    (issue_mem_sgpr),
        .decoded           (decoded)
    );

    ////////////////////////////////////////
    // execute, gpr read
    ////////////////////////////////////////
    lsu_operand_fetch #(
        .NUM_SGPRS (NUM_SGPRS),
        .NUM_VGPRS (NUM_VGPRS)
    ) u_operand_fetch (
        .clk         (clk),
        .reset       (reset),
        .decoded     (decoded),
        .issue_valid (lsu_selected),
        .preload     (preload),
        .operands    (operands)
    );

    // result, +2 cycles from strobe
    lsu_addr_calc u_addr_calc (
        .clk        (clk),
        .reset      (reset),
        .operands   (operands),
        .mem_req    (mem_req),
        .illegal_op (illegal_op)
    );

endmodule

/* verilog/lsu_addr_calc.sv */
module lsu_addr_calc (
    input  logic                        clk,
    input  logic                        reset,
    input  lsu_pipe_pkg::lsu_operands_t operands,
    output lsu_pipe_pkg::mem_req_t      mem_req,
    output logic                        illegal_op
);

    lsu_isa_pkg::lsu_decoded_t dec;

    logic [31:0] smrd_offset;
    logic [31:0] addr_next;
    logic [31:0] data_next;
    logic        req_fire;
    logic        illegal_fire;

    assign dec          = operands.decoded;
    assign req_fire     = operands.valid && dec.legal;
    assign illegal_fire = operands.valid && !dec.legal;

    // immediate is in dwords
    assign smrd_offset = dec.sgpr_source1_rd_en ? operands.sgpr1
                                                : {22'd0, dec.smrd_imm, 2'b00};

    ////////////////////////////////////////
    // address and store data per format
    ////////////////////////////////////////
    always_comb
    begin
        addr_next = 32'd0;
        data_next = 32'd0;
        case (dec.fmt)
            lsu_isa_pkg::smrd_format:
                addr_next = operands.sgpr2 + smrd_offset;   // no store data
            lsu_isa_pkg::ds_format:
            begin
                addr_next = operands.vgpr2;
                data_next = operands.vgpr1;
            end
            lsu_isa_pkg::mtbuf_format:
            begin
                addr_next = operands.sgpr1 + operands.sgpr2 + operands.vgpr2;
                data_next = operands.vgpr1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // result stage register
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        mem_req.cnt     <= dec.mem_op_cnt;
        mem_req.depth   <= dec.gpr_op_depth;
        mem_req.wr_mask <= dec.sgpr_wr_mask;
        mem_req.addr    <= addr_next;
        mem_req.data    <= data_next;

        if (reset)
        begin
            mem_req.valid <= 1'b0;
            mem_req.rd    <= 1'b0;
            mem_req.wr    <= 1'b0;
            mem_req.gpr   <= 1'b0;
            illegal_op    <= 1'b0;
        end
        else
        begin
            mem_req.valid <= req_fire;
            mem_req.rd    <= req_fire && dec.mem_op_rd;
            mem_req.wr    <= req_fire && dec.mem_op_wr;
            mem_req.gpr   <= req_fire && dec.mem_gpr;
            illegal_op    <= illegal_fire;   // instead of a request
        end
    end

endmodule

/* verilog/lsu_operand_fetch.sv */
module lsu_operand_fetch #(
    parameter int NUM_SGPRS = 512,
    parameter int NUM_VGPRS = 1024
) (
    input  logic                        clk,
    input  logic                        reset,
    input  lsu_isa_pkg::lsu_decoded_t   decoded,
    input  logic                        issue_valid,
    input  lsu_pipe_pkg::gpr_preload_t  preload,
    output lsu_pipe_pkg::lsu_operands_t operands
);

    localparam int SGPR_AW = (NUM_SGPRS > 1) ? $clog2(NUM_SGPRS) : 1;
    localparam int VGPR_AW = (NUM_VGPRS > 1) ? $clog2(NUM_VGPRS) : 1;

    logic [31:0] sgpr_file [NUM_SGPRS];
    logic [31:0] vgpr_file [NUM_VGPRS];

    logic [SGPR_AW-1:0] pre_sgpr_idx;
    logic [VGPR_AW-1:0] pre_vgpr_idx;
    logic [SGPR_AW-1:0] sgpr1_idx;
    logic [SGPR_AW-1:0] sgpr2_idx;
    logic [VGPR_AW-1:0] vgpr1_idx;
    logic [VGPR_AW-1:0] vgpr2_idx;

    ////////////////////////////////////////
    // index folding, modulo file depth
    ////////////////////////////////////////
    assign pre_sgpr_idx = SGPR_AW'(preload.index % NUM_SGPRS);
    assign pre_vgpr_idx = VGPR_AW'(preload.index % NUM_VGPRS);
    assign sgpr1_idx    = SGPR_AW'(decoded.sgpr_source1_addr % NUM_SGPRS);
    assign sgpr2_idx    = SGPR_AW'(decoded.sgpr_source2_addr % NUM_SGPRS);
    assign vgpr1_idx    = VGPR_AW'(decoded.vgpr_source1_addr % NUM_VGPRS);
    assign vgpr2_idx    = VGPR_AW'(decoded.vgpr_source2_addr % NUM_VGPRS);

    // preload port, one word per clock
    always_ff @(posedge clk)
    begin
        if (preload.en && !preload.is_vgpr)
            sgpr_file[pre_sgpr_idx] <= preload.data;
        if (preload.en && preload.is_vgpr)
            vgpr_file[pre_vgpr_idx] <= preload.data;
    end

    ////////////////////////////////////////
    // execute stage register
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        operands.decoded <= decoded;

        operands.sgpr1 <= decoded.sgpr_source1_rd_en ? sgpr_file[sgpr1_idx] : 32'd0;
        operands.sgpr2 <= decoded.sgpr_source2_rd_en ? sgpr_file[sgpr2_idx] : 32'd0;

        // data and address vgprs are always read as a pair
        operands.vgpr1 <= decoded.vgpr_source2_rd_en ? vgpr_file[vgpr1_idx] : 32'd0;
        operands.vgpr2 <= decoded.vgpr_source2_rd_en ? vgpr_file[vgpr2_idx] : 32'd0;

        if (reset)
            operands.valid <= 1'b0;
        else
            operands.valid <= issue_valid;   // one cycle per strobe
    end

endmodule

/* verilog/lsu_opcode_decoder.sv */
module lsu_opcode_decoder (
    input  logic                        lsu_selected,
    input  logic [31:0]                 lsu_opcode,
    input  lsu_isa_pkg::operand_field_u issue_source_reg1,
    input  lsu_isa_pkg::operand_field_u issue_source_reg2,
    input  lsu_isa_pkg::operand_field_u issue_source_reg3,
    input  lsu_isa_pkg::operand_field_u issue_mem_sgpr,
    output lsu_isa_pkg::lsu_decoded_t   decoded
);

    logic [7:0] fmt;
    logic [7:0] op;
    logic       imm_sel;
    logic       op_hit;   // some table entry matched

    assign fmt     = lsu_opcode[31:24];
    assign op      = lsu_opcode[7:0];
    assign imm_sel = lsu_opcode[lsu_isa_pkg::smrd_imm_bit];

    always_comb
    begin
        decoded     = '0;
        decoded.fmt = fmt;
        op_hit      = 1'b0;

        if (lsu_selected)
        begin
            case (fmt)
                ////////////////////////////////////////
                // smrd: base in source2, offset in source1
                ////////////////////////////////////////
                lsu_isa_pkg::smrd_format:
                begin
                    decoded.sgpr_source1_addr  = issue_source_reg1.sgpr.index;
                    decoded.sgpr_source2_addr  = issue_source_reg2.sgpr.index;
                    decoded.sgpr_source2_rd_en = 1'b1;
                    decoded.sgpr_source1_rd_en = !imm_sel;
                    if (imm_sel)
                        decoded.smrd_imm = issue_source_reg1.sgpr.index[7:0];
                    decoded.mem_op_rd = 1'b1;   // loads only, no dcache_inv
                    case (op)
                        lsu_isa_pkg::s_load_dword:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_cnt   = 6'd0;
                            decoded.sgpr_wr_mask = 4'b0001;
                        end
                        lsu_isa_pkg::s_load_dwordx2:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_cnt   = 6'd1;
                            decoded.sgpr_wr_mask = 4'b0011;
                        end
                        lsu_isa_pkg::s_load_dwordx4:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_cnt   = 6'd3;
                            decoded.sgpr_wr_mask = 4'b1111;
                        end
                        lsu_isa_pkg::s_load_dwordx8:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_cnt   = 6'd3;
                            decoded.sgpr_wr_mask = 4'b1111;
                            decoded.gpr_op_depth = 2'b01;   // two passes of x4
                        end
                        lsu_isa_pkg::s_load_dwordx16:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_cnt   = 6'd3;
                            decoded.sgpr_wr_mask = 4'b1111;
                            decoded.gpr_op_depth = 2'b10;
                        end
                        default: ;
                    endcase
                end

                ////////////////////////////////////////
                // ds: vgpr address and data
                ////////////////////////////////////////
                lsu_isa_pkg::ds_format:
                begin
                    decoded.vgpr_source1_addr  = issue_source_reg2.vgpr.index;   // data0
                    decoded.vgpr_source2_addr  = issue_source_reg1.vgpr.index;   // addr
                    decoded.vgpr_source2_rd_en = 1'b1;
                    decoded.mem_gpr            = 1'b1;
                    case (op)
                        lsu_isa_pkg::ds_read_b32:
                        begin
                            op_hit            = 1'b1;
                            decoded.mem_op_rd = 1'b1;
                        end
                        lsu_isa_pkg::ds_write_b32:
                        begin
                            op_hit            = 1'b1;
                            decoded.mem_op_wr = 1'b1;
                        end
                        default: ;
                    endcase
                end

                ////////////////////////////////////////
                // mtbuf: resource, soffset, vaddr, vdata
                ////////////////////////////////////////
                lsu_isa_pkg::mtbuf_format:
                begin
                    decoded.vgpr_source1_addr  = issue_source_reg2.vgpr.index;
                    decoded.vgpr_source2_addr  = issue_source_reg3.vgpr.index;
                    decoded.sgpr_source1_addr  = issue_mem_sgpr.sgpr.index;
                    decoded.sgpr_source2_addr  = issue_source_reg1.sgpr.index;
                    decoded.sgpr_source1_rd_en = 1'b1;
                    decoded.sgpr_source2_rd_en = 1'b1;
                    decoded.vgpr_source2_rd_en = 1'b1;
                    decoded.mem_gpr            = 1'b1;
                    case (op)
                        lsu_isa_pkg::tbuffer_load_format_x,
                        lsu_isa_pkg::tbuffer_load_format_xy,
                        lsu_isa_pkg::tbuffer_load_format_xyz,
                        lsu_isa_pkg::tbuffer_load_format_xyzw:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_rd    = 1'b1;
                            decoded.mem_op_cnt   = 6'd63;    // all 64 lanes
                            decoded.gpr_op_depth = op[1:0];  // x .. xyzw
                        end
                        lsu_isa_pkg::tbuffer_store_format_x,
                        lsu_isa_pkg::tbuffer_store_format_xy,
                        lsu_isa_pkg::tbuffer_store_format_xyz,
                        lsu_isa_pkg::tbuffer_store_format_xyzw:
                        begin
                            op_hit               = 1'b1;
                            decoded.mem_op_wr    = 1'b1;
                            decoded.mem_op_cnt   = 6'd63;
                            decoded.gpr_op_depth = op[1:0];
                        end
                        default: ;
                    endcase
                end

                default: ;   // unknown format
            endcase
        end

        decoded.legal = !lsu_selected || op_hit;
    end

endmodule

/* verilog/lsu_pipe_pkg.sv */
package lsu_pipe_pkg;

    ////////////////////////////////////////
    // decode -> execute record
    ////////////////////////////////////////
    typedef struct packed {
        logic                      valid;
        lsu_isa_pkg::lsu_decoded_t decoded;
        logic [31:0]               sgpr1;
        logic [31:0]               sgpr2;
        logic [31:0]               vgpr1;   // store data
        logic [31:0]               vgpr2;   // vector address
    } lsu_operands_t;

    ////////////////////////////////////////
    // memory request, one per instruction
    ////////////////////////////////////////
    typedef struct packed {
        logic        valid;
        logic        rd;
        logic        wr;
        logic        gpr;
        logic [5:0]  cnt;
        logic [1:0]  depth;
        logic [3:0]  wr_mask;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    // register file fill port
    typedef struct packed {
        logic        en;
        logic        is_vgpr;
        logic [9:0]  index;
        logic [31:0] data;
    } gpr_preload_t;

endpackage

/* verilog/lsu_isa_pkg.sv */
package lsu_isa_pkg;

    ////////////////////////////////////////
    // instruction formats, opcode[31:24]
    ////////////////////////////////////////
    parameter logic [7:0] smrd_format  = 8'h01;
    parameter logic [7:0] ds_format    = 8'h02;
    parameter logic [7:0] mtbuf_format = 8'h04;

    // smrd: offset field holds an immediate
    parameter int smrd_imm_bit = 8;

    ////////////////////////////////////////
    // opcode numbers, opcode[7:0]
    ////////////////////////////////////////
    parameter logic [7:0] s_load_dword    = 8'd0;
    parameter logic [7:0] s_load_dwordx2  = 8'd1;
    parameter logic [7:0] s_load_dwordx4  = 8'd2;
    parameter logic [7:0] s_load_dwordx8  = 8'd3;
    parameter logic [7:0] s_load_dwordx16 = 8'd4;

    parameter logic [7:0] ds_read_b32  = 8'h36;
    parameter logic [7:0] ds_write_b32 = 8'h0D;

    parameter logic [7:0] tbuffer_load_format_x     = 8'd0;
    parameter logic [7:0] tbuffer_load_format_xy    = 8'd1;
    parameter logic [7:0] tbuffer_load_format_xyz   = 8'd2;
    parameter logic [7:0] tbuffer_load_format_xyzw  = 8'd3;
    parameter logic [7:0] tbuffer_store_format_x    = 8'd4;
    parameter logic [7:0] tbuffer_store_format_xy   = 8'd5;
    parameter logic [7:0] tbuffer_store_format_xyz  = 8'd6;
    parameter logic [7:0] tbuffer_store_format_xyzw = 8'd7;

    // operand field, read per format as sgpr or vgpr index
    typedef struct packed {
        logic [2:0] pad;
        logic [8:0] index;
    } sgpr_field_t;

    typedef struct packed {
        logic [1:0] pad;
        logic [9:0] index;
    } vgpr_field_t;

    typedef union packed {
        sgpr_field_t sgpr;
        vgpr_field_t vgpr;
    } operand_field_u;

    typedef struct packed {
        logic       legal;
        logic [7:0] fmt;
        logic       sgpr_source1_rd_en;
        logic       sgpr_source2_rd_en;
        logic [8:0] sgpr_source1_addr;
        logic [8:0] sgpr_source2_addr;
        logic       vgpr_source2_rd_en;
        logic [9:0] vgpr_source1_addr;
        logic [9:0] vgpr_source2_addr;
        logic [5:0] mem_op_cnt;
        logic       mem_op_rd;
        logic       mem_op_wr;
        logic       mem_gpr;       // 0 sgpr, 1 vgpr
        logic [3:0] sgpr_wr_mask;
        logic [1:0] gpr_op_depth;
        logic [7:0] smrd_imm;      // dword offset
    } lsu_decoded_t;

endpackage
